/* hw/fpu_pkg.sv */
// single-precision format definitions shared by the converters
// class and flag bit positions, rounding modes, format constants
package fpu_pkg;

    // ------------------------------
    // format
    localparam int fp_exp_w_c = 8;    // exponent field width
    localparam int fp_man_w_c = 23;   // stored mantissa width
    localparam int fp_bias_c  = 127;  // exponent bias

    // ------------------------------
    // operand class, fclass bit order
    typedef logic [9:0] fp_class_t;

    localparam int fp_class_neg_inf_c     = 0;
    localparam int fp_class_neg_norm_c    = 1;
    localparam int fp_class_neg_subnorm_c = 2;
    localparam int fp_class_neg_zero_c    = 3;
    localparam int fp_class_pos_zero_c    = 4;
    localparam int fp_class_pos_subnorm_c = 5;
    localparam int fp_class_pos_norm_c    = 6;
    localparam int fp_class_pos_inf_c     = 7;
    localparam int fp_class_snan_c        = 8;
    localparam int fp_class_qnan_c        = 9;

    // ------------------------------
    // exception flags, fflags layout
    typedef logic [4:0] fflags_t;

    localparam int fp_exc_nv_c = 4;  // invalid
    localparam int fp_exc_dz_c = 3;  // divide by zero, never raised here
    localparam int fp_exc_of_c = 2;  // overflow
    localparam int fp_exc_uf_c = 1;  // underflow
    localparam int fp_exc_nx_c = 0;  // inexact

    // rounding modes, frm encoding
    typedef enum logic [2:0] {
        rne = 3'd0,  // nearest, ties to even
        rtz = 3'd1,  // toward zero
        rdn = 3'd2,  // toward -inf
        rup = 3'd3,  // toward +inf
        rmm = 3'd4   // nearest, ties away
    } rmode_e;

endpackage

/* hw/cvt_pkg.sv */
// request and response types of the conversion unit
package cvt_pkg;
    import fpu_pkg::*;

    // ------------------------------
    // operation select
    typedef enum logic {
        op_f2i = 1'b0,  // float to integer
        op_i2f = 1'b1   // integer to float
    } cvt_op_e;

    // request port payload
    typedef struct packed {
        cvt_op_e     op;
        logic        unsign;   // 1 = unsigned integer side
        rmode_e      rmode;
        logic [31:0] operand;  // float bits or integer
    } cvt_req_t;

    // response port payload
    typedef struct packed {
        logic [31:0] result;
        fflags_t     flags;    // fflags of this conversion
    } cvt_rsp_t;

endpackage

/* hw/fpu_classify.sv */
// single-precision operand unpacker
// splits sign, exponent and mantissa and builds the one-hot fclass vector
`timescale 1ns/1ps

module fpu_classify
    import fpu_pkg::*;
(
    input  logic [31:0]           operand_i,
    output logic                  sign_o,
    output logic [fp_exp_w_c-1:0] exponent_o,
    output logic [fp_man_w_c-1:0] mantissa_o,
    output fp_class_t             class_o
);

    logic exp_max;   // all ones, inf or nan
    logic exp_zero;  // zero or subnormal
    logic man_zero;

    assign sign_o     = operand_i[31];
    assign exponent_o = operand_i[fp_man_w_c +: fp_exp_w_c];
    assign mantissa_o = operand_i[fp_man_w_c-1:0];

    assign exp_max  = &exponent_o;
    assign exp_zero = ~|exponent_o;
    assign man_zero = ~|mantissa_o;

    always_comb begin
        class_o = '0;
        if (exp_max) begin
            if (man_zero) begin
                class_o[sign_o ? fp_class_neg_inf_c : fp_class_pos_inf_c] = 1'b1;
            end else if (mantissa_o[fp_man_w_c-1]) begin  // quiet bit
                class_o[fp_class_qnan_c] = 1'b1;
            end else begin
                class_o[fp_class_snan_c] = 1'b1;
            end
        end else if (exp_zero) begin
            if (man_zero) begin
                class_o[sign_o ? fp_class_neg_zero_c : fp_class_pos_zero_c] = 1'b1;
            end else begin
                class_o[sign_o ? fp_class_neg_subnorm_c : fp_class_pos_subnorm_c] = 1'b1;
            end
        end else begin
            class_o[sign_o ? fp_class_neg_norm_c : fp_class_pos_norm_c] = 1'b1;
        end
    end

endmodule

/* hw/fpu_f2i.sv */
// serial float-to-integer converter
// shifts the mantissa into the integer one bit per cycle, then rounds and saturates
`timescale 1ns/1ps

module fpu_f2i
    import fpu_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        start_i,     // one-cycle trigger
    input  logic        unsign_i,    // 1 = unsigned result
    input  rmode_e      rmode_i,     // stable for the whole op
    input  logic        sign_i,
    input  logic [7:0]  exponent_i,
    input  logic [22:0] mantissa_i,
    input  fp_class_t   class_i,
    output logic [31:0] result_o,
    output fflags_t     flags_o,
    output logic        done_o       // one-cycle pulse
);

    localparam logic [7:0] bias_c    = 8'(fp_bias_c);
    localparam logic [7:0] ovf_exp_c = 8'(fp_bias_c + 32);  // |x| >= 2^32

    typedef enum logic [2:0] {s_idle, s_prepare, s_shift, s_round, s_final} state_e;

    typedef struct packed {
        logic [31:0] int_part;  // integer bits so far
        logic [23:0] frac;      // msb is next bit in
        logic        sticky;    // bits lost before the shift
    } sreg_t;

    state_e      state_q;
    sreg_t       sreg_q;
    logic [7:0]  cnt_q;    // exponent, then shifts left
    logic        sign_q;   // sign latched at start
    logic        under_q;  // magnitude below 0.5
    logic        nx_q;
    logic [32:0] mag_q;    // rounded magnitude + carry

    logic        is_nan;
    logic        is_zero;
    logic        special;
    logic        grd;
    logic        rnd;
    logic        stk;
    logic        inc;
    logic [32:0] mag_rnd;
    logic        over;

    assign is_nan  = class_i[fp_class_snan_c] | class_i[fp_class_qnan_c];
    assign is_zero = class_i[fp_class_pos_zero_c] | class_i[fp_class_neg_zero_c];
    assign special = is_nan | is_zero | class_i[fp_class_pos_inf_c]
                   | class_i[fp_class_neg_inf_c] | (exponent_i >= ovf_exp_c);

    // ------------------------------
    // rounding
    assign grd = sreg_q.frac[23];
    assign rnd = sreg_q.frac[22];
    assign stk = (|sreg_q.frac[21:0]) | sreg_q.sticky;

    always_comb begin
        case (rmode_i)
            rne:     inc = grd & (rnd | stk | sreg_q.int_part[0]);  // tie goes to even
            rtz:     inc = 1'b0;
            rdn:     inc = sign_q & (grd | rnd | stk);
            rup:     inc = ~sign_q & (grd | rnd | stk);
            rmm:     inc = grd;
            default: inc = 1'b0;  // reserved codes truncate
        endcase
    end

    assign mag_rnd = {1'b0, sreg_q.int_part} + 33'(inc);

    // -2^31 still fits a signed result
    assign over = mag_q[32]
                | (~unsign_i & (sign_q ? (mag_q[31:0] > 32'h8000_0000) : mag_q[31]));

    function automatic logic [31:0] sat_value(input logic neg, input logic uns);
        if (uns) begin
            sat_value = neg ? 32'h0000_0000 : 32'hffff_ffff;
        end else begin
            sat_value = neg ? 32'h8000_0000 : 32'h7fff_ffff;
        end
    endfunction

    // ------------------------------
    // control engine
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q  <= s_idle;
            sreg_q   <= '0;
            cnt_q    <= '0;
            sign_q   <= 1'b0;
            under_q  <= 1'b0;
            nx_q     <= 1'b0;
            mag_q    <= '0;
            result_o <= '0;
            flags_o  <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                s_idle: begin
                    if (start_i) begin
                        sign_q      <= sign_i;
                        cnt_q       <= exponent_i;
                        sreg_q.frac <= {mantissa_i, 1'b0};
                        under_q     <= 1'b0;
                        if (special) begin  // finishes right away
                            done_o  <= 1'b1;
                            flags_o <= '0;
                            if (is_nan) begin
                                result_o             <= sat_value(1'b0, unsign_i);
                                flags_o[fp_exc_nv_c] <= 1'b1;
                            end else if (is_zero) begin
                                result_o <= '0;
                            end else begin  // inf or too large
                                result_o             <= sat_value(sign_i, unsign_i);
                                flags_o[fp_exc_of_c] <= 1'b1;
                            end
                        end else begin
                            state_q <= s_prepare;
                        end
                    end
                end
                s_prepare: begin
                    sreg_q.sticky <= 1'b0;
                    if (cnt_q >= bias_c) begin  // at least 1.0
                        sreg_q.int_part <= 32'd1;  // hidden one
                        cnt_q           <= cnt_q - bias_c;
                        state_q         <= (cnt_q == bias_c) ? s_round : s_shift;
                    end else if (cnt_q == bias_c - 8'd1) begin  // in [0.5, 1.0)
                        sreg_q.int_part <= '0;
                        sreg_q.frac     <= {1'b1, sreg_q.frac[23:1]};
                        state_q         <= s_round;
                    end else begin  // below 0.5, only sticky left
                        sreg_q.int_part <= '0;
                        sreg_q.frac     <= '0;
                        sreg_q.sticky   <= 1'b1;
                        under_q         <= 1'b1;
                        state_q         <= s_round;
                    end
                end
                s_shift: begin
                    sreg_q.int_part <= {sreg_q.int_part[30:0], sreg_q.frac[23]};
                    sreg_q.frac     <= {sreg_q.frac[22:0], 1'b0};
                    cnt_q           <= cnt_q - 8'd1;
                    if (cnt_q == 8'd1) begin
                        state_q <= s_round;
                    end
                end
                s_round: begin
                    mag_q   <= mag_rnd;
                    nx_q    <= grd | rnd | stk;  // any fraction dropped
                    state_q <= s_final;
                end
                s_final: begin
                    done_o               <= 1'b1;
                    flags_o              <= '0;
                    flags_o[fp_exc_of_c] <= over;
                    flags_o[fp_exc_uf_c] <= under_q;
                    flags_o[fp_exc_nx_c] <= nx_q;
                    if (over) begin
                        result_o <= sat_value(sign_q, unsign_i);
                    end else if (sign_q && unsign_i) begin  // negative clamps to 0
                        result_o <= '0;
                    end else if (sign_q) begin
                        result_o <= 32'd0 - mag_q[31:0];
                    end else begin
                        result_o <= mag_q[31:0];
                    end
                    state_q <= s_idle;
                end
                default: state_q <= s_idle;
            endcase
        end
    end

endmodule

/* hw/fpu_i2f.sv */
// serial integer-to-float normalizer
// shifts the magnitude up to the leading one, rounds to 24 bits and packs a single
`timescale 1ns/1ps

module fpu_i2f
    import fpu_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        start_i,   // one-cycle trigger
    input  logic        unsign_i,  // 1 = operand is unsigned
    input  rmode_e      rmode_i,
    input  logic [31:0] int_i,
    output logic [31:0] result_o,
    output fflags_t     flags_o,   // only nx can rise
    output logic        done_o
);

    localparam logic [7:0] exp_top_c = 8'(fp_bias_c + 31);  // leading one at bit 31

    typedef enum logic [1:0] {s_idle, s_norm, s_round, s_pack} state_e;

    state_e      state_q;
    logic        sign_q;
    logic [31:0] mag_q;   // magnitude being normalized
    logic [7:0]  exp_q;
    logic [22:0] man_q;
    logic        nx_q;

    logic        neg;
    logic [31:0] abs_val;
    logic        grd;
    logic        stk;
    logic        inc;
    logic [24:0] sig_rnd;  // carry + 24-bit significand

    assign neg     = ~unsign_i & int_i[31];
    assign abs_val = neg ? (32'd0 - int_i) : int_i;

    // ------------------------------
    // rounding of the top 24 bits
    assign grd = mag_q[7];
    assign stk = |mag_q[6:0];

    always_comb begin
        case (rmode_i)
            rne:     inc = grd & (stk | mag_q[8]);
            rtz:     inc = 1'b0;
            rdn:     inc = sign_q & (grd | stk);
            rup:     inc = ~sign_q & (grd | stk);
            rmm:     inc = grd;
            default: inc = 1'b0;
        endcase
    end

    assign sig_rnd = {1'b0, mag_q[31:8]} + 25'(inc);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q  <= s_idle;
            sign_q   <= 1'b0;
            mag_q    <= '0;
            exp_q    <= '0;
            man_q    <= '0;
            nx_q     <= 1'b0;
            result_o <= '0;
            flags_o  <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                s_idle: begin  // load cycle
                    if (start_i) begin
                        sign_q <= neg;
                        mag_q  <= abs_val;
                        exp_q  <= exp_top_c;
                        if (int_i == 32'd0) begin  // +0, done at once
                            result_o <= '0;
                            flags_o  <= '0;
                            done_o   <= 1'b1;
                        end else begin
                            state_q <= abs_val[31] ? s_round : s_norm;
                        end
                    end
                end
                s_norm: begin
                    mag_q <= {mag_q[30:0], 1'b0};
                    exp_q <= exp_q - 8'd1;
                    if (mag_q[30]) begin  // leading one reaches bit 31
                        state_q <= s_round;
                    end
                end
                s_round: begin
                    nx_q    <= grd | stk;
                    man_q   <= sig_rnd[22:0];                // zero after a carry
                    exp_q   <= exp_q + {7'd0, sig_rnd[24]};  // carry bumps exponent
                    state_q <= s_pack;
                end
                s_pack: begin
                    result_o             <= {sign_q, exp_q, man_q};
                    flags_o              <= '0;
                    flags_o[fp_exc_nx_c] <= nx_q;
                    done_o               <= 1'b1;
                    state_q              <= s_idle;
                end
                default: state_q <= s_idle;
            endcase
        end
    end

endmodule

/* hw/cvt_sequencer.sv */
// request/response sequencer of the conversion unit
// holds one request, starts the chosen converter and keeps the response until taken
`timescale 1ns/1ps

module cvt_sequencer
    import fpu_pkg::*, cvt_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  cvt_req_t    req_i,
    input  logic        req_valid_i,
    output logic        req_ready_o,
    output cvt_rsp_t    rsp_o,
    output logic        rsp_valid_o,
    input  logic        rsp_ready_i,
    output logic [31:0] operand_o,    // to classifier and i2f
    output logic        unsign_o,
    output rmode_e      rmode_o,
    output logic        f2i_start_o,
    output logic        i2f_start_o,
    input  logic        f2i_done_i,
    input  logic [31:0] f2i_result_i,
    input  fflags_t     f2i_flags_i,
    input  logic        i2f_done_i,
    input  logic [31:0] i2f_result_i,
    input  fflags_t     i2f_flags_i
);

    typedef enum logic [1:0] {s_idle, s_busy, s_resp} state_e;

    state_e   state_q;
    logic     start_q;  // cycle after acceptance
    cvt_req_t req_q;
    cvt_rsp_t rsp_q;

    assign req_ready_o = (state_q == s_idle);
    assign rsp_valid_o = (state_q == s_resp);
    assign rsp_o       = rsp_q;

    assign operand_o   = req_q.operand;
    assign unsign_o    = req_q.unsign;
    assign rmode_o     = req_q.rmode;
    assign f2i_start_o = start_q & (req_q.op == op_f2i);
    assign i2f_start_o = start_q & (req_q.op == op_i2f);

    // ------------------------------
    // control
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= s_idle;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state_q)
                s_idle: begin
                    if (req_valid_i) begin
                        start_q <= 1'b1;
                        state_q <= s_busy;
                    end
                end
                s_busy: if (f2i_done_i || i2f_done_i) state_q <= s_resp;
                s_resp: if (rsp_ready_i) state_q <= s_idle;  // response taken
                default: state_q <= s_idle;
            endcase
        end
    end

    // request and response registers
    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;
        end
        if (state_q == s_busy && f2i_done_i) begin
            rsp_q.result <= f2i_result_i;
            rsp_q.flags  <= f2i_flags_i;
        end else if (state_q == s_busy && i2f_done_i) begin
            rsp_q.result <= i2f_result_i;
            rsp_q.flags  <= i2f_flags_i;
        end
    end

endmodule

/* hw/cvt_unit.sv */
// float/integer conversion unit, top level
// sequencer, operand classifier and the two serial converters
`timescale 1ns/1ps

module cvt_unit
    import fpu_pkg::*, cvt_pkg::*;
(
    input  logic     clk_i,
    input  logic     rstn_i,
    input  cvt_req_t req_i,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    output cvt_rsp_t rsp_o,
    output logic     rsp_valid_o,
    input  logic     rsp_ready_i
);

    logic [31:0] operand;
    logic        unsign;
    rmode_e      rmode;
    logic        f2i_start;
    logic        i2f_start;

    logic        op_sign;      // unpacked operand
    logic [7:0]  op_exponent;
    logic [22:0] op_mantissa;
    fp_class_t   op_class;

    logic        f2i_done;
    logic [31:0] f2i_result;
    fflags_t     f2i_flags;
    logic        i2f_done;
    logic [31:0] i2f_result;
    fflags_t     i2f_flags;

    cvt_sequencer cvt_sequencer_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_i        (req_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .rsp_o        (rsp_o),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .operand_o    (operand),
        .unsign_o     (unsign),
        .rmode_o      (rmode),
        .f2i_start_o  (f2i_start),
        .i2f_start_o  (i2f_start),
        .f2i_done_i   (f2i_done),
        .f2i_result_i (f2i_result),
        .f2i_flags_i  (f2i_flags),
        .i2f_done_i   (i2f_done),
        .i2f_result_i (i2f_result),
        .i2f_flags_i  (i2f_flags)
    );

    fpu_classify fpu_classify_inst (
        .operand_i  (operand),
        .sign_o     (op_sign),
        .exponent_o (op_exponent),
        .mantissa_o (op_mantissa),
        .class_o    (op_class)
    );

    fpu_f2i fpu_f2i_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .start_i    (f2i_start),
        .unsign_i   (unsign),
        .rmode_i    (rmode),
        .sign_i     (op_sign),
        .exponent_i (op_exponent),
        .mantissa_i (op_mantissa),
        .class_i    (op_class),
        .result_o   (f2i_result),
        .flags_o    (f2i_flags),
        .done_o     (f2i_done)
    );

    fpu_i2f fpu_i2f_inst (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .start_i  (i2f_start),
        .unsign_i (unsign),
        .rmode_i  (rmode),
        .int_i    (operand),  // raw operand bits
        .result_o (i2f_result),
        .flags_o  (i2f_flags),
        .done_o   (i2f_done)
    );

endmodule

/* test/cvt_unit_chk.sv */
// handshake checker of the conversion unit
// bound into the top level, covers response hold, port exclusion and reset state
`timescale 1ns/1ps

module cvt_unit_chk
    import cvt_pkg::*;
(
    input logic     clk_i,
    input logic     rstn_i,
    input logic     req_ready_o,
    input cvt_rsp_t rsp_o,
    input logic     rsp_valid_o,
    input logic     rsp_ready_i
);

    // ------------------------------
    // response port
    rsp_hold_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)))
        else $error("response dropped or changed while stalled");

    // one request at a time
    port_excl_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(req_ready_o && rsp_valid_o))
        else $error("request ready and response valid together");

    rst_idle_a: assert property (@(posedge clk_i)
        !rstn_i |-> !rsp_valid_o)
        else $error("response valid during reset");

endmodule

/* test/cvt_unit_tb.sv */
// testbench of the float/integer conversion unit
// directed corners and seeded random operands, checked against a reference model
`timescale 1ns/1ps

module cvt_unit_tb
    import fpu_pkg::*, cvt_pkg::*;
;

    localparam int n_random_c = 200;  // random requests per direction

    logic     clk_i;
    logic     rstn_i;
    cvt_req_t req_i;
    logic     req_valid_i;
    logic     req_ready_o;
    cvt_rsp_t rsp_o;
    logic     rsp_valid_o;
    logic     rsp_ready_i;

    integer   seed;
    logic     stall_en;          // random rsp_ready_i when set
    int       stall_from;        // first request run under stall
    int       val_errs;
    int       other_errs;
    int       rsp_cnt;

    cvt_req_t req_list  [$];     // full stimulus, built at time 0
    string    name_list [$];
    cvt_rsp_t exp_q     [$];     // expected responses in order
    string    exp_name_q[$];

    cvt_unit cvt_unit_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .rsp_o       (rsp_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i)
    );

    bind cvt_unit cvt_unit_chk cvt_unit_chk_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_ready_o (req_ready_o),
        .rsp_o       (rsp_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;  // 10 ns period
    end

    // ------------------------------
    // reference model
    function automatic logic round_up(input logic [2:0] mode, input logic sign,
                                      input logic lsb, input logic half, input logic rest);
        case (mode)
            rne:     round_up = half & (rest | lsb);
            rtz:     round_up = 1'b0;
            rdn:     round_up = sign & (half | rest);
            rup:     round_up = ~sign & (half | rest);
            rmm:     round_up = half;
            default: round_up = 1'b0;  // reserved codes truncate
        endcase
    endfunction

    function automatic cvt_rsp_t float_to_int(input logic [31:0] op, input logic uns,
                                              input logic [2:0] mode);
        cvt_rsp_t    r;
        logic        sign;
        logic [7:0]  e;
        logic [22:0] m;
        logic [63:0] fixed;   // 32.32 fixed point
        logic [31:0] ipart;
        logic        half;
        logic        rest;
        logic        under;
        logic [32:0] mag;
        logic [31:0] sat;
        sign = op[31];
        e    = op[30:23];
        m    = op[22:0];
        r    = '0;
        sat  = uns ? (sign ? 32'h0000_0000 : 32'hffff_ffff)
                   : (sign ? 32'h8000_0000 : 32'h7fff_ffff);
        if (e == 8'hff && m != '0) begin  // nan, positive limit
            r.result             = uns ? 32'hffff_ffff : 32'h7fff_ffff;
            r.flags[fp_exc_nv_c] = 1'b1;
        end else if (e == 8'd0 && m == '0) begin
            r.result = '0;
        end else if (e >= 8'd159) begin  // inf or |x| >= 2^32
            r.result             = sat;
            r.flags[fp_exc_of_c] = 1'b1;
        end else begin
            if (e < 8'd126) begin  // below 0.5, subnormals too
                ipart = '0;
                half  = 1'b0;
                rest  = 1'b1;
                under = 1'b1;
            end else begin
                fixed = {40'd0, 1'b1, m} << (int'(e) - 118);
                ipart = fixed[63:32];
                half  = fixed[31];
                rest  = |fixed[30:0];
                under = 1'b0;
            end
            mag = {1'b0, ipart} + 33'(round_up(mode, sign, ipart[0], half, rest));
            r.flags[fp_exc_nx_c] = half | rest;
            r.flags[fp_exc_uf_c] = under;
            if (uns) begin
                if (mag[32]) begin
                    r.result             = sat;
                    r.flags[fp_exc_of_c] = 1'b1;
                end else begin
                    r.result = sign ? 32'd0 : mag[31:0];  // negatives clamp to 0
                end
            end else if (sign ? (mag > 33'h0_8000_0000) : (mag >= 33'h0_8000_0000)) begin
                r.result             = sat;
                r.flags[fp_exc_of_c] = 1'b1;
            end else begin
                r.result = sign ? (32'd0 - mag[31:0]) : mag[31:0];
            end
        end
        return r;
    endfunction

    function automatic cvt_rsp_t int_to_float(input logic [31:0] op, input logic uns,
                                              input logic [2:0] mode);
        cvt_rsp_t    r;
        logic        sign;
        logic [31:0] a;
        logic [31:0] norm;   // leading one at bit 31
        logic [24:0] sig;
        logic [7:0]  ex;
        logic        half;
        logic        rest;
        int          p;
        r    = '0;
        sign = ~uns & op[31];
        a    = sign ? (32'd0 - op) : op;
        p    = 0;
        if (a != '0) begin  // zero stays +0, no flags
            for (int i = 0; i < 32; i++) begin
                if (a[i]) p = i;  // highest set bit
            end
            norm = a << (31 - p);
            half = norm[7];
            rest = |norm[6:0];
            sig  = {1'b0, norm[31:8]} + 25'(round_up(mode, sign, norm[8], half, rest));
            ex   = 8'(fp_bias_c + p);
            if (sig[24]) begin  // rounded up to the next power of two
                ex  = ex + 8'd1;
                sig = sig >> 1;
            end
            r.result             = {sign, ex, sig[22:0]};
            r.flags[fp_exc_nx_c] = half | rest;
        end
        return r;
    endfunction

    function automatic cvt_rsp_t ref_convert(input cvt_req_t req);
        if (req.op == op_f2i) begin
            return float_to_int(req.operand, req.unsign, req.rmode);
        end
        return int_to_float(req.operand, req.unsign, req.rmode);
    endfunction

    // ------------------------------
    // stimulus
    task automatic queue_request(input cvt_op_e op, input logic uns, input logic [2:0] mode,
                                 input logic [31:0] v, input string kind);
        cvt_req_t req;
        req.op      = op;
        req.unsign  = uns;
        req.rmode   = rmode_e'(mode);
        req.operand = v;
        req_list.push_back(req);
        name_list.push_back($sformatf("%s %s m%0d %08h", kind, uns ? "u" : "s", mode, v));
    endtask

    task automatic build_requests();
        logic [31:0] fvals [$];
        logic [31:0] ivals [$];
        logic [31:0] v;
        logic        u;
        logic [2:0]  m;
        int          sh;
        // halves, ties, tiny, zeros, specials, limits around 2^31 and 2^32
        fvals = '{32'h3fc0_0000, 32'h4020_0000, 32'hbfc0_0000, 32'hc020_0000,
                  32'h3f00_0000, 32'h3f40_0000, 32'h3e80_0000, 32'h0000_0001,
                  32'h8000_0000, 32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000,
                  32'h7f80_0001, 32'h4f00_0000, 32'hcf00_0000, 32'h4f80_0000,
                  32'hcf00_0001, 32'h4eff_ffff, 32'h4f7f_ffff, 32'h3f80_0000,
                  32'h4b7f_ffff, 32'h4049_0fdb};
        ivals = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h7fff_ffff,
                  32'h8000_0000, 32'h0100_0001, 32'h0100_0003, 32'h00ff_ffff,
                  32'h1234_5678, 32'h0180_0001};
        foreach (fvals[i]) begin
            for (int k = 0; k < 10; k++) begin
                queue_request(op_f2i, k[0], 3'(k / 2), fvals[i], "f2i");
            end
        end
        foreach (ivals[i]) begin
            for (int k = 0; k < 10; k++) begin
                queue_request(op_i2f, k[0], 3'(k / 2), ivals[i], "i2f");
            end
        end
        stall_from = req_list.size();
        for (int n = 0; n < n_random_c; n++) begin
            v = $random(seed);
            u = $random(seed);
            m = $random(seed);   // reserved codes too
            sh = {$random(seed)} % 44;
            if (v[0]) v[30:23] = 8'd118 + 8'(sh);  // keep most near the integer range
            queue_request(op_f2i, u, m, v, "f2i rnd");
            v = $random(seed);
            u = $random(seed);
            m = $random(seed);
            sh = {$random(seed)} % 32;
            if (v[1]) v = v >> sh;  // small magnitudes, fewer dropped bits
            queue_request(op_i2f, u, m, v, "i2f rnd");
        end
    endtask

    task automatic send_request(input cvt_req_t req, input string name);
        @(negedge clk_i);
        req_i       = req;
        req_valid_i = 1'b1;
        while (!req_ready_o) @(negedge clk_i);  // ready holds until the next edge
        exp_q.push_back(ref_convert(req));
        exp_name_q.push_back(name);
        @(negedge clk_i);                        // taken at the edge in between
        req_valid_i = 1'b0;
    endtask

    // ------------------------------
    // response compare, also drives rsp_ready_i
    initial begin : compare
        cvt_rsp_t exp_rsp;
        string    exp_name;
        forever begin
            @(negedge clk_i);
            if (rstn_i) begin
                rsp_ready_i = stall_en ? 1'($random(seed)) : 1'b1;
                if (rsp_valid_o && req_ready_o) begin
                    $display("request port ready while a response is pending");
                    other_errs++;
                end
                if (rsp_valid_o && rsp_ready_i) begin  // handshake at the next edge
                    if (exp_q.size() == 0) begin
                        $display("response arrived with no request outstanding");
                        other_errs++;
                    end else begin
                        exp_rsp  = exp_q.pop_front();
                        exp_name = exp_name_q.pop_front();
                        rsp_cnt++;
                        if (rsp_o.result !== exp_rsp.result) begin
                            $display("ERR %s result: expected %08h, actual %08h",
                                     exp_name, exp_rsp.result, rsp_o.result);
                            val_errs++;
                        end
                        if (rsp_o.flags !== exp_rsp.flags) begin
                            $display("ERR %s flags: expected %05b, actual %05b",
                                     exp_name, exp_rsp.flags, rsp_o.flags);
                            val_errs++;
                        end
                    end
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = req_list.size() * 200 + 1000;  // cycles
        repeat (limit) @(posedge clk_i);
        $display("timeout after %0d cycles, %0d responses seen", limit, rsp_cnt);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------
    // main sequence
    initial begin
        seed        = 32'hf816;
        stall_en    = 1'b0;
        val_errs    = 0;
        other_errs  = 0;
        rsp_cnt     = 0;
        rstn_i      = 1'b0;
        req_i       = '0;
        req_valid_i = 1'b0;
        rsp_ready_i = 1'b1;
        build_requests();
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        if (rsp_valid_o !== 1'b0) begin
            $display("response valid during reset");
            other_errs++;
        end
        rstn_i = 1'b1;
        @(negedge clk_i);
        if (req_ready_o !== 1'b1 || rsp_valid_o !== 1'b0) begin
            $display("after reset the request port is not ready or a response is valid");
            other_errs++;
        end
        foreach (req_list[i]) begin
            if (i == stall_from) stall_en = 1'b1;  // back-pressure phase
            send_request(req_list[i], name_list[i]);
        end
        while (exp_q.size() != 0) @(negedge clk_i);
        repeat (2) @(negedge clk_i);
        if (rsp_valid_o !== 1'b0) begin
            $display("response still valid after the last request was answered");
            other_errs++;
        end
        $display("responses %0d, value errors %0d, other errors %0d",
                 rsp_cnt, val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
hw/fpu_pkg.sv
hw/cvt_pkg.sv
hw/fpu_classify.sv
hw/fpu_f2i.sv
hw/fpu_i2f.sv
hw/cvt_sequencer.sv
hw/cvt_unit.sv
test/cvt_unit_chk.sv
test/cvt_unit_tb.sv
